/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_rv_core
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_exec.sv
rv_ctrl.sv
rv_core.sv
tb_rv_core.sv

/* rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// ----------------------------------------
// Core configuration
// ----------------------------------------

// Data and address width.
`define RV_XLEN     32

// RV32E register file.
`define RV_NREGS    16
`define RV_REG_AW   4

// First fetch address.
`define RV_RESET_PC 32'h0000_0000

`endif

/* rv_core.sv */
`include "rv_cfg.svh"

module rv_core
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    output logic                imem_req_valid,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic                imem_rsp_valid,
    input  logic [31:0]         imem_rsp_inst,
    output logic                commit_valid,
    output commit_t             commit,
    output logic                halted
);

    fetch_bus_t          fetch;
    logic                fetch_load;
    logic                exec_load;
    logic                rf_we;
    decode_bus_t         dec;
    commit_t             exec_result;
    logic [`RV_XLEN-1:0] rdata1;
    logic [`RV_XLEN-1:0] rdata2;

    rv_ctrl i_rv_ctrl (
        .clk            (clk),
        .rst            (rst),
        .imem_req_valid (imem_req_valid),
        .imem_addr      (imem_addr),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_inst  (imem_rsp_inst),
        .fetch          (fetch),
        .fetch_load     (fetch_load),
        .exec_load      (exec_load),
        .exec_result    (exec_result),
        .rf_we          (rf_we),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .halted         (halted)
    );

    rv_decode i_rv_decode (
        .clk        (clk),
        .rst        (rst),
        .fetch      (fetch),
        .fetch_load (fetch_load),
        .dec        (dec)
    );

    // Write port is fed from the result register.
    rv_regfile i_rv_regfile (
        .clk    (clk),
        .rst    (rst),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .rd     (exec_result.rd),
        .wdata  (exec_result.wdata)
    );

    rv_exec i_rv_exec (
        .clk       (clk),
        .rst       (rst),
        .exec_load (exec_load),
        .dec       (dec),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .result    (exec_result)
    );

endmodule

/* rv_ctrl.sv */
`include "rv_cfg.svh"

module rv_ctrl
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    output logic                imem_req_valid,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic                imem_rsp_valid,
    input  logic [31:0]         imem_rsp_inst,
    output fetch_bus_t          fetch,
    output logic                fetch_load,
    output logic                exec_load,
    input  commit_t             exec_result,
    output logic                rf_we,
    output logic                commit_valid,
    output commit_t             commit,
    output logic                halted
);

    ctrl_state_e         state;
    logic                req_q;
    logic [`RV_XLEN-1:0] pc_q;
    logic                halting;

    assign halting = exec_result.halt | exec_result.illegal;

    // ----------------------------------------
    // State machine
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_fetch;
            req_q <= 1'b0;
            pc_q  <= `RV_RESET_PC;
        end else begin
            case (state)
                st_fetch: begin
                    if (req_q) begin
                        req_q <= 1'b0;              // Accepted, drop it.
                        state <= st_decode;
                    end else begin
                        req_q <= 1'b1;              // First request after reset.
                    end
                end
                st_decode: begin
                    if (imem_rsp_valid) begin
                        state <= st_exec;
                    end
                end
                st_exec: begin
                    state <= st_commit;
                end
                st_commit: begin
                    pc_q <= exec_result.next_pc;
                    if (halting) begin
                        state <= st_halted;
                    end else begin
                        req_q <= 1'b1;
                        state <= st_fetch;
                    end
                end
                st_halted: begin
                    state <= st_halted;             // Until reset.
                end
                default: begin
                    state <= st_fetch;
                end
            endcase
        end
    end

    assign imem_req_valid = req_q;
    assign imem_addr      = pc_q;

    assign fetch.pc   = pc_q;
    assign fetch.inst = imem_rsp_inst;
    assign fetch_load = (state == st_decode) && imem_rsp_valid;
    assign exec_load  = (state == st_exec);

    assign commit_valid = (state == st_commit);
    assign commit       = exec_result;
    assign rf_we        = commit_valid && exec_result.gpr_we;
    assign halted       = (state == st_halted);

endmodule

/* rv_decode.sv */
`include "rv_cfg.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  fetch_bus_t  fetch,
    input  logic        fetch_load,
    output decode_bus_t dec
);

    logic [31:0]         inst;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [4:0]          rs1_f;
    logic [4:0]          rs2_f;
    logic [4:0]          rd_f;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic                is_op;
    logic                is_op_imm;
    logic                is_lui;
    logic                is_auipc;
    logic                is_jal;
    logic                is_jalr;
    logic                is_branch;
    logic                is_ebreak;
    logic                op_ok;
    logic                op_imm_ok;
    logic                legal;
    logic                uses_rs1;
    logic                uses_rs2;
    logic                uses_rd;
    logic                reg_bad;
    logic                illegal;
    alu_op_e             alu_op;
    br_op_e              br_op;
    decode_bus_t         dec_d;

    // ----------------------------------------
    // Fields and immediates
    // ----------------------------------------

    assign inst   = fetch.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1_f  = inst[19:15];
    assign rs2_f  = inst[24:20];
    assign rd_f   = inst[11:7];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // ----------------------------------------
    // Instruction match
    // ----------------------------------------

    assign is_op     = (opcode == 7'h33);
    assign is_op_imm = (opcode == 7'h13);
    assign is_lui    = (opcode == 7'h37);
    assign is_auipc  = (opcode == 7'h17);
    assign is_jal    = (opcode == 7'h6f);
    assign is_jalr   = (opcode == 7'h67) & (funct3 == 3'h0);
    assign is_branch = (opcode == 7'h63) & (funct3 != 3'h2) & (funct3 != 3'h3);
    assign is_ebreak = (opcode == 7'h73) & (funct3 == 3'h0) & (rd_f == 5'h0)
                     & (rs1_f == 5'h0) & (inst[31:20] == 12'h001);

    // Only sub and sra take funct7 0x20.
    assign op_ok = is_op & ((funct7 == 7'h00)
                 | ((funct7 == 7'h20) & ((funct3 == 3'h0) | (funct3 == 3'h5))));

    // Shift immediates carry funct7 in the upper bits.
    assign op_imm_ok = is_op_imm & ((funct3 == 3'h1) ? (funct7 == 7'h00) :
                                    (funct3 == 3'h5) ? ((funct7 == 7'h00) | (funct7 == 7'h20)) :
                                    1'b1);

    assign legal = op_ok | op_imm_ok | is_lui | is_auipc | is_jal | is_jalr
                 | is_branch | is_ebreak;

    assign uses_rs1 = is_op | is_op_imm | is_jalr | is_branch;
    assign uses_rs2 = is_op | is_branch;
    assign uses_rd  = is_op | is_op_imm | is_lui | is_auipc | is_jal | is_jalr;

    // RV32E has no x16..x31.
    assign reg_bad = (uses_rs1 & rs1_f[4]) | (uses_rs2 & rs2_f[4]) | (uses_rd & rd_f[4]);
    assign illegal = ~legal | reg_bad;

    always_comb begin
        alu_op = alu_add;
        if (is_lui) begin
            alu_op = alu_pass_b;
        end else if (is_op | is_op_imm) begin
            case (funct3)
                3'h0:    alu_op = (is_op & funct7[5]) ? alu_sub : alu_add;
                3'h1:    alu_op = alu_sll;
                3'h2:    alu_op = alu_slt;
                3'h3:    alu_op = alu_sltu;
                3'h4:    alu_op = alu_xor;
                3'h5:    alu_op = funct7[5] ? alu_sra : alu_srl;
                3'h6:    alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    always_comb begin
        br_op = br_none;
        if (is_branch) begin
            case (funct3)
                3'h0:    br_op = br_beq;
                3'h1:    br_op = br_bne;
                3'h4:    br_op = br_blt;
                3'h5:    br_op = br_bge;
                3'h6:    br_op = br_bltu;
                default: br_op = br_bgeu;
            endcase
        end
    end

    // ----------------------------------------
    // Decode bundle
    // ----------------------------------------

    assign dec_d.pc  = fetch.pc;
    assign dec_d.imm = ({`RV_XLEN{is_op_imm | is_jalr}} & imm_i)
                     | ({`RV_XLEN{is_branch}}           & imm_b)
                     | ({`RV_XLEN{is_lui | is_auipc}}   & imm_u)
                     | ({`RV_XLEN{is_jal}}              & imm_j);
    assign dec_d.rs1         = rs1_f[`RV_REG_AW-1:0];
    assign dec_d.rs2         = rs2_f[`RV_REG_AW-1:0];
    assign dec_d.rd          = rd_f[`RV_REG_AW-1:0];
    assign dec_d.alu_op      = alu_op;
    assign dec_d.br_op       = br_op;
    assign dec_d.src1_is_pc  = is_jal | is_auipc | is_branch;     // Targets use the ALU.
    assign dec_d.src2_is_imm = is_op_imm | is_lui | is_auipc | is_jal | is_jalr | is_branch;
    assign dec_d.gpr_we      = uses_rd & ~illegal;
    assign dec_d.is_jal      = is_jal;
    assign dec_d.is_jalr     = is_jalr;
    assign dec_d.is_ebreak   = is_ebreak;
    assign dec_d.illegal     = illegal;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec <= '0;
        end else if (fetch_load) begin
            dec <= dec_d;
        end
    end

endmodule

/* rv_exec.sv */
`include "rv_cfg.svh"

module rv_exec
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                exec_load,
    input  decode_bus_t         dec,
    input  logic [`RV_XLEN-1:0] rdata1,
    input  logic [`RV_XLEN-1:0] rdata2,
    output commit_t             result
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] seq_pc;
    logic [`RV_XLEN-1:0] next_pc;
    logic [4:0]          shamt;
    logic                taken;
    commit_t             res_d;

    assign op_a   = dec.src1_is_pc  ? dec.pc  : rdata1;
    assign op_b   = dec.src2_is_imm ? dec.imm : rdata2;
    assign shamt  = op_b[4:0];
    assign seq_pc = dec.pc + `RV_XLEN'd4;

    // ----------------------------------------
    // ALU
    // ----------------------------------------

    always_comb begin
        case (dec.alu_op)
            alu_add:    alu_res = op_a + op_b;
            alu_sub:    alu_res = op_a - op_b;
            alu_slt:    alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            alu_and:    alu_res = op_a & op_b;
            alu_or:     alu_res = op_a | op_b;
            alu_xor:    alu_res = op_a ^ op_b;
            alu_sll:    alu_res = op_a << shamt;
            alu_srl:    alu_res = op_a >> shamt;
            alu_sra:    alu_res = $signed(op_a) >>> shamt;
            alu_pass_b: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // Compare always uses the register operands.
    always_comb begin
        case (dec.br_op)
            br_beq:  taken = (rdata1 == rdata2);
            br_bne:  taken = (rdata1 != rdata2);
            br_blt:  taken = ($signed(rdata1) <  $signed(rdata2));
            br_bge:  taken = ($signed(rdata1) >= $signed(rdata2));
            br_bltu: taken = (rdata1 <  rdata2);
            br_bgeu: taken = (rdata1 >= rdata2);
            default: taken = 1'b0;
        endcase
    end

    // Branch and jal targets come out of the ALU as pc + imm.
    always_comb begin
        if (dec.is_jalr) begin
            next_pc = {alu_res[`RV_XLEN-1:1], 1'b0};
        end else if (dec.is_jal || taken) begin
            next_pc = alu_res;
        end else begin
            next_pc = seq_pc;
        end
    end

    // ----------------------------------------
    // Result register
    // ----------------------------------------

    assign res_d.pc      = dec.pc;
    assign res_d.next_pc = next_pc;
    assign res_d.rd      = dec.rd;
    assign res_d.wdata   = (dec.is_jal || dec.is_jalr) ? seq_pc : alu_res;  // Link value.
    assign res_d.gpr_we  = dec.gpr_we;
    assign res_d.illegal = dec.illegal;
    assign res_d.halt    = dec.is_ebreak;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else if (exec_load) begin
            result <= res_d;
        end
    end

endmodule

/* rv_pkg.sv */
`include "rv_cfg.svh"

package rv_pkg;

    // ----------------------------------------
    // Enums
    // ----------------------------------------

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b                              // For lui.
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu
    } br_op_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,                              // Waits for the response.
        st_exec,
        st_commit,
        st_halted
    } ctrl_state_e;

    // ----------------------------------------
    // Stage bundles
    // ----------------------------------------

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         inst;
    } fetch_bus_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   imm;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        alu_op_e               alu_op;
        br_op_e                br_op;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  gpr_we;
        logic                  is_jal;
        logic                  is_jalr;
        logic                  is_ebreak;
        logic                  illegal;
    } decode_bus_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   next_pc;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   wdata;
        logic                  gpr_we;
        logic                  illegal;
        logic                  halt;
    } commit_t;

endpackage

/* rv_regfile.sv */
`include "rv_cfg.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`RV_REG_AW-1:0] rs1,
    input  logic [`RV_REG_AW-1:0] rs2,
    output logic [`RV_XLEN-1:0]   rdata1,
    output logic [`RV_XLEN-1:0]   rdata2,
    input  logic                  we,
    input  logic [`RV_REG_AW-1:0] rd,
    input  logic [`RV_XLEN-1:0]   wdata
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero.
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* tb_rv_core.sv */
`include "rv_cfg.svh"

module tb_rv_core
    import rv_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_LEN = 200;
    localparam int TIMEOUT  = PROG_LEN * 8 + 200;    // Worst case is 7 cycles per instruction.

    logic                clk;
    logic                rst;
    logic                imem_req_valid;
    logic [`RV_XLEN-1:0] imem_addr;
    logic                imem_rsp_valid = 1'b0;
    logic [31:0]         imem_rsp_inst  = '0;
    logic                commit_valid;
    commit_t             commit;
    logic                halted;

    logic [31:0]         imem [256];
    logic [31:0]         ref_regs [`RV_NREGS];
    logic [`RV_XLEN-1:0] ref_pc;
    logic                targeted [PROG_LEN + 1];
    integer              seed;
    int                  cycle     = 0;
    int                  rsp_cycle = 0;
    int                  halts     = 0;
    int                  wait_cnt  = 0;
    logic                pending     = 1'b0;
    logic                outstanding = 1'b0;
    logic [`RV_XLEN-1:0] req_addr    = '0;

    rv_core i_rv_core (
        .clk            (clk),
        .rst            (rst),
        .imem_req_valid (imem_req_valid),
        .imem_addr      (imem_addr),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_inst  (imem_rsp_inst),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .halted         (halted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // ----------------------------------------
    // Error reporting
    // ----------------------------------------

    task automatic fail_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        $display("test failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic fail_text(input string msg);
        $display("%s at %0d ns", msg, $time);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    // ----------------------------------------
    // Instruction encoders
    // ----------------------------------------

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [3:0] rs2,
                                          input logic [3:0] rs1, input logic [2:0] f3,
                                          input logic [3:0] rd);
        return {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, 7'h33};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [3:0] rs1,
                                          input logic [2:0] f3, input logic [3:0] rd,
                                          input logic [6:0] op);
        return {imm, 1'b0, rs1, f3, 1'b0, rd, op};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [3:0] rs2,
                                          input logic [3:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], 1'b0, rs2, 1'b0, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [3:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 1'b0, rd, 7'h6f};
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'h0: begin
                if (alt) return a - b;
                return a + b;
            end
            3'h1: return a << b[4:0];
            3'h2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'h3: return (a < b) ? 32'd1 : 32'd0;
            3'h4: return a ^ b;
            3'h5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'h6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'h0: return a == b;
            3'h1: return a != b;
            3'h4: return $signed(a) < $signed(b);
            3'h5: return $signed(a) >= $signed(b);
            3'h6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic commit_t ref_step(input logic [31:0] pc, input logic [31:0] inst);
        commit_t     c;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        c         = '0;
        c.pc      = pc;
        c.next_pc = pc + 32'd4;
        c.rd      = inst[10:7];
        a         = ref_regs[inst[18:15]];
        b         = ref_regs[inst[23:20]];
        imm_i     = {{20{inst[31]}}, inst[31:20]};
        imm_b     = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        case (inst[6:0])
            7'h33: begin
                c.wdata   = alu_ref(inst[14:12], inst[30], a, b);
                c.gpr_we  = 1'b1;
                c.illegal = inst[11] | inst[19] | inst[24];
            end
            7'h13: begin
                c.wdata   = alu_ref(inst[14:12], inst[30] && (inst[14:12] == 3'h5), a, imm_i);
                c.gpr_we  = 1'b1;
                c.illegal = inst[11] | inst[19];
            end
            7'h37, 7'h17: begin
                c.wdata   = (inst[5] ? 32'd0 : pc) + {inst[31:12], 12'h000};
                c.gpr_we  = 1'b1;
                c.illegal = inst[11];
            end
            7'h6f: begin
                c.wdata   = pc + 32'd4;
                c.next_pc = pc + imm_j;
                c.gpr_we  = 1'b1;
                c.illegal = inst[11];
            end
            7'h67: begin
                c.wdata   = pc + 32'd4;
                c.next_pc = (a + imm_i) & ~32'd1;           // Bit 0 dropped.
                c.gpr_we  = 1'b1;
                c.illegal = inst[11] | inst[19];
            end
            7'h63: begin
                if (branch_ref(inst[14:12], a, b)) c.next_pc = pc + imm_b;
                c.illegal = inst[19] | inst[24];
            end
            7'h73: c.halt = 1'b1;
            default: c.illegal = 1'b1;
        endcase
        if (c.illegal) c.gpr_we = 1'b0;
        if (c.gpr_we && c.rd != 4'd0) ref_regs[c.rd] = c.wdata;
        return c;
    endfunction

    // ----------------------------------------
    // Instruction responder and timeout
    // ----------------------------------------

    task automatic drive_rsp(input logic [31:0] addr);
        imem_rsp_valid <= 1'b1;
        imem_rsp_inst  <= imem[addr[9:2]];
        rsp_cycle      <= cycle;
    endtask

    always @(posedge clk) begin
        logic [31:0] rnd;
        cycle <= cycle + 1;
        assert (cycle < TIMEOUT) else fail_text("Timeout, the core never halted");
        if (rst) begin
            imem_rsp_valid <= 1'b0;
            pending        <= 1'b0;
            outstanding    <= 1'b0;
        end else begin
            imem_rsp_valid <= 1'b0;
            if (commit_valid) outstanding <= 1'b0;
            if (imem_req_valid) begin
                assert (!outstanding)
                    else fail_text("A request was made while another one was outstanding");
                assert (imem_addr == ref_pc)
                    else fail_value("imem_addr", imem_addr, ref_pc);
                rnd = $random(seed);
                outstanding <= 1'b1;
                if (rnd[1:0] == 2'd0) begin
                    drive_rsp(imem_addr);                    // One cycle latency.
                end else begin
                    req_addr <= imem_addr;
                    wait_cnt <= int'(rnd[1:0]);
                    pending  <= 1'b1;
                end
            end else if (pending) begin
                if (wait_cnt == 1) begin
                    drive_rsp(req_addr);
                    pending <= 1'b0;
                end
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    // ----------------------------------------
    // Commit checker
    // ----------------------------------------

    always @(posedge clk) begin
        commit_t exp;
        if (rst) begin
            ref_pc = `RV_RESET_PC;
            for (int k = 0; k < `RV_NREGS; k++) begin
                ref_regs[k] = '0;
            end
        end else if (commit_valid) begin
            exp = ref_step(ref_pc, imem[ref_pc[9:2]]);
            assert (cycle - rsp_cycle == 3)
                else fail_value("commit_valid delay", 32'(cycle - rsp_cycle), 32'd3);
            assert (commit.pc == exp.pc) else fail_value("pc", commit.pc, exp.pc);
            assert (commit.illegal == exp.illegal)
                else fail_value("illegal", 32'(commit.illegal), 32'(exp.illegal));
            assert (commit.halt == exp.halt)
                else fail_value("halt", 32'(commit.halt), 32'(exp.halt));
            assert (commit.gpr_we == exp.gpr_we)
                else fail_value("gpr_we", 32'(commit.gpr_we), 32'(exp.gpr_we));
            if (!exp.illegal) begin
                assert (commit.next_pc == exp.next_pc)
                    else fail_value("next_pc", commit.next_pc, exp.next_pc);
            end
            if (exp.gpr_we) begin
                assert (commit.rd == exp.rd) else fail_value("rd", 32'(commit.rd), 32'(exp.rd));
                assert (commit.wdata == exp.wdata) else fail_value("wdata", commit.wdata, exp.wdata);
            end
            ref_pc = exp.next_pc;
            if (exp.halt || exp.illegal) halts <= halts + 1;
        end
    end

    task automatic check_quiet();
        repeat (10) begin
            @(posedge clk);
            assert (halted) else fail_text("halted is low after a halting commit");
            assert (!imem_req_valid) else fail_text("A request followed a halting commit");
        end
    endtask

    // ----------------------------------------
    // Program and run
    // ----------------------------------------

    initial begin
        logic [31:0] rnd;
        logic [3:0]  rd;
        logic [3:0]  base;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          i;
        int          tgt;
        int          bval;
        seed = 32'hedd3_086e;
        rst  = 1'b1;
        for (int k = 0; k < 256; k++) begin
            imem[k] = $random(seed);
        end
        for (int k = 0; k <= PROG_LEN; k++) begin
            targeted[k] = 1'b0;
        end
        i = 0;
        while (i < PROG_LEN) begin
            rnd = $random(seed);
            rd  = rnd[7:4];
            f3  = rnd[10:8];
            tgt = i + 1 + int'(rnd[13:11]);                  // Forward only.
            if (tgt > PROG_LEN) tgt = PROG_LEN;
            case (rnd[2:0])
                3'd0, 3'd1: begin
                    imem[i] = rtype((rnd[14] && (f3 == 3'h0 || f3 == 3'h5)) ? 7'h20 : 7'h00,
                                    rnd[18:15], rnd[22:19], f3, rd);
                end
                3'd2, 3'd3: begin
                    imm = rnd[31:20];
                    if (f3 == 3'h1) imm = {7'h00, rnd[24:20]};
                    if (f3 == 3'h5) imm = {(rnd[30] ? 7'h20 : 7'h00), rnd[24:20]};
                    imem[i] = itype(imm, rnd[18:15], f3, rd, 7'h13);
                end
                3'd4: imem[i] = {rnd[31:12], 1'b0, rd, (rnd[11] ? 7'h37 : 7'h17)};
                3'd5: begin
                    if (f3 == 3'h2 || f3 == 3'h3) f3 = 3'h0;
                    imem[i] = btype(13'((tgt - i) * 4), rnd[18:15], rnd[22:19], f3);
                    targeted[tgt] = 1'b1;
                end
                3'd6: begin
                    imem[i] = jtype(21'((tgt - i) * 4), rd);
                    targeted[tgt] = 1'b1;
                end
                default: begin
                    // Base from auipc unless a branch lands between the pair.
                    base = rnd[18:15];
                    bval = 0;
                    if (base != 4'd0 && i + 2 < PROG_LEN && !targeted[i + 1]) begin
                        imem[i] = {20'h00000, 1'b0, base, 7'h17};
                        bval    = i * 4;
                        i       = i + 1;
                    end else begin
                        base = 4'd0;
                    end
                    tgt = i + 1 + int'(rnd[13:11]);
                    if (tgt > PROG_LEN) tgt = PROG_LEN;
                    imem[i] = itype(12'(tgt * 4 - bval + int'(rnd[14])), base, 3'h0, rd, 7'h67);
                    targeted[tgt] = 1'b1;
                end
            endcase
            i = i + 1;
        end
        imem[PROG_LEN] = 32'h0010_0073;                      // ebreak.

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        wait (halts == 1);
        check_quiet();

        // Second run, addi x20, x0, 1 at the reset PC.
        @(posedge clk);
        rst <= 1'b1;
        imem[0] = {12'h001, 5'd0, 3'h0, 5'd20, 7'h13};
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        wait (halts == 2);
        check_quiet();

        $display("test passed");
        $finish;
    end

endmodule
